// File: Bender.yml
package:
  name: icache

sources:
  - icache_pkg.sv
  - tag_store.sv
  - data_store.sv
  - miss_fsm.sv
  - victim_counter.sv
  - icache_top.sv
  - target: test
    files:
      - icache_properties.sv
      - icache_checker.sv
      - tb_icache.sv

// File: data_store.sv
`default_nettype none

module data_store #(
  parameter int unsigned FETCH_WIDTH = 2
) (
  input  logic                   clk,
  input  logic                   reset,
  input  icache_pkg::index_t     lookup_index_i,
  input  icache_pkg::offset_t    lookup_offset_i,
  input  icache_pkg::way_mask_t  hit_way_i,
  input  icache_pkg::fill_t      fill_i,
  output icache_pkg::inst_t      inst_o [FETCH_WIDTH],
  output logic [FETCH_WIDTH-1:0] inst_valid_o
);

  import icache_pkg::*;

  // line storage for every way and set
  line_t data_q [NUM_SETS][NUM_WAYS];

  // line of the hitting way, zero when no way hits
  line_t hit_line;
  // the same line cut into its instruction words
  inst_t line_words [INSTS_IN_LINE];
  logic  any_hit;

  //////////////////////////////
  // fill write
  //////////////////////////////

  // no line is written while reset is held
  always_ff @(posedge clk)
  begin
    if (!reset && fill_i.valid)
    begin
      data_q[fill_i.index][fill_i.way] <= fill_i.data;
    end
  end

  //////////////////////////////
  // line select
  //////////////////////////////

  assign any_hit = |hit_way_i;

  // the hit mask is one-hot, so an and-or mux picks the line
  // without a priority chain over the ways
  always_comb
  begin
    hit_line = '0;
    for (int w = 0; w < NUM_WAYS; w++)
    begin
      if (hit_way_i[w])
      begin
        hit_line = hit_line | data_q[lookup_index_i][w];
      end
    end
  end

  for (genvar k = 0; k < INSTS_IN_LINE; k++)
  begin : g_word
    assign line_words[k] = hit_line[k*INST_BITS +: INST_BITS];
  end

  //////////////////////////////
  // fetch slots
  //////////////////////////////

  // slot i carries instruction offset+i of the line
  // slots that run past the end of the line are not valid, fetch
  // picks those up from the next line on its following request
  for (genvar i = 0; i < FETCH_WIDTH; i++)
  begin : g_slot
    // one extra bit so that offset+i cannot wrap back into the line
    logic [OFFSET_BITS:0] slot;

    assign slot            = {1'b0, lookup_offset_i} + (OFFSET_BITS+1)'(i);
    assign inst_valid_o[i] = any_hit && (slot < INSTS_IN_LINE);
    // invalid slots carry zero data
    assign inst_o[i]       = inst_valid_o[i] ? line_words[slot[OFFSET_BITS-1:0]] : '0;
  end

endmodule

`default_nettype wire

// File: icache_checker.sv
`default_nettype none

module icache_checker #(
  parameter int unsigned FETCH_WIDTH = 2
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   fetch_req_i,
  input  icache_pkg::pc_t        pc_i,
  input  icache_pkg::inst_t      inst_i [FETCH_WIDTH],
  input  logic [FETCH_WIDTH-1:0] inst_valid_i,
  input  icache_pkg::mem_req_t   mem_req_i,
  input  icache_pkg::mem_resp_t  mem_resp_i,
  input  logic                   flush_i,
  input  logic                   flush_done_i,
  input  logic                   ic_miss_i,
  output int                     error_count_o
);

  import icache_pkg::*;

  // reference copy of the cache contents
  logic   valid_m [NUM_SETS][NUM_WAYS];
  tag_t   tag_m   [NUM_SETS][NUM_WAYS];
  way_t   ptr_m   [NUM_SETS];

  // reference miss holder
  // req_due means a request pulse is expected in the current cycle
  logic   req_due;
  logic   waiting;
  logic   fill_due;
  logic   flush_prev;
  tag_t   held_tag;
  index_t held_index;

  int hit_errors   = 0;
  int data_errors  = 0;
  int req_errors   = 0;
  int flush_errors = 0;

  assign error_count_o = hit_errors + data_errors + req_errors + flush_errors;

  // memory content rule, word k of a block is its address with k below it
  function automatic inst_t expected_word(input tag_t tag, input index_t index, input int k);
    return {tag, index, 4'(k)};
  endfunction

  task automatic report_error(input string msg);
    $display("** Error at time %0t: %s", $time, msg);
  endtask

  task automatic clear_model();
    for (int s = 0; s < NUM_SETS; s++)
    begin
      ptr_m[s] = '0;
      for (int w = 0; w < NUM_WAYS; w++)
      begin
        valid_m[s][w] = 1'b0;
      end
    end
    req_due    = 1'b0;
    waiting    = 1'b0;
    fill_due   = 1'b0;
    flush_prev = 1'b0;
  endtask

  task automatic print_counts(input int assert_errors);
    $display("checker: %0d hit, %0d data, %0d request, %0d flush, %0d assertion errors",
             hit_errors, data_errors, req_errors, flush_errors, assert_errors);
  endtask

  //////////////////////////////
  // per-cycle compare
  //////////////////////////////

  // everything is sampled mid-cycle where the outputs have settled
  // the model then steps as if the closing edge had happened
  always @(negedge clk)
  begin : check_cycle
    tag_t    tag;
    index_t  index;
    offset_t offset;
    logic    hit;
    logic    idle;
    logic    exp_valid;
    inst_t   exp_inst;
    int      slot;

    tag    = pc_i[PC_BITS-1 -: TAG_BITS];
    index  = pc_i[INST_BYTE_BITS+OFFSET_BITS +: INDEX_BITS];
    offset = pc_i[INST_BYTE_BITS +: OFFSET_BITS];

    if (reset)
    begin
      clear_model();
      if (mem_req_i.valid !== 1'b0 || ic_miss_i !== 1'b0 || flush_done_i !== 1'b0)
      begin
        req_errors++;
        report_error("request, miss or flush done not low in reset");
      end
    end
    else
    begin
      hit = 1'b0;
      for (int w = 0; w < NUM_WAYS; w++)
      begin
        if (fetch_req_i && valid_m[index][w] && tag_m[index][w] == tag)
        begin
          hit = 1'b1;
        end
      end

      // slot i is instruction offset+i, and only while it stays in the line
      for (int i = 0; i < FETCH_WIDTH; i++)
      begin
        slot      = int'(offset) + i;
        exp_valid = hit && (slot < INSTS_IN_LINE);
        exp_inst  = exp_valid ? expected_word(tag, index, slot) : '0;
        if (inst_valid_i[i] !== exp_valid)
        begin
          hit_errors++;
          report_error($sformatf("pc %h slot %0d valid %b, expected %b",
                                 pc_i, i, inst_valid_i[i], exp_valid));
        end
        else if (inst_i[i] !== exp_inst)
        begin
          data_errors++;
          report_error($sformatf("pc %h slot %0d data %h, expected %h",
                                 pc_i, i, inst_i[i], exp_inst));
        end
      end

      if (mem_req_i.valid !== req_due || ic_miss_i !== req_due)
      begin
        req_errors++;
        report_error($sformatf("request %b miss %b, expected %b",
                               mem_req_i.valid, ic_miss_i, req_due));
      end
      else if (req_due && mem_req_i.addr !== {held_tag, held_index})
      begin
        req_errors++;
        report_error($sformatf("request address %h, expected %h",
                               mem_req_i.addr, {held_tag, held_index}));
      end

      if (flush_done_i !== flush_prev)
      begin
        flush_errors++;
        report_error($sformatf("flush done %b, expected %b", flush_done_i, flush_prev));
      end

      // step the model across the closing edge
      idle = !req_due && !waiting && !fill_due;
      if (flush_i)
      begin
        // a flush empties the cache and drops the miss, pointers stay
        for (int s = 0; s < NUM_SETS; s++)
        begin
          for (int w = 0; w < NUM_WAYS; w++)
          begin
            valid_m[s][w] = 1'b0;
          end
        end
        req_due  = 1'b0;
        waiting  = 1'b0;
        fill_due = 1'b0;
      end
      else
      begin
        if (fill_due)
        begin
          valid_m[held_index][ptr_m[held_index]] = 1'b1;
          tag_m[held_index][ptr_m[held_index]]   = held_tag;
          ptr_m[held_index] = way_t'((int'(ptr_m[held_index]) + 1) % NUM_WAYS);
          fill_due = 1'b0;
        end
        if (waiting && mem_resp_i.valid && mem_resp_i.tag == held_tag &&
            mem_resp_i.index == held_index)
        begin
          waiting  = 1'b0;
          fill_due = 1'b1;
        end
        if (req_due)
        begin
          req_due = 1'b0;
          waiting = 1'b1;
        end
        else if (idle && fetch_req_i && !hit)
        begin
          req_due    = 1'b1;
          held_tag   = tag;
          held_index = index;
        end
      end
      flush_prev = flush_i;
    end
  end

endmodule

`default_nettype wire

// File: icache_pkg.sv
`default_nettype none

package icache_pkg;

  //////////////////////////////
  // cache geometry
  //////////////////////////////

  localparam int unsigned PC_BITS        = 32;
  localparam int unsigned INST_BITS      = 32;
  localparam int unsigned INSTS_IN_LINE  = 4;
  // byte offset below each instruction, always zero for aligned fetch
  localparam int unsigned INST_BYTE_BITS = 2;
  // instruction slot within a line
  localparam int unsigned OFFSET_BITS    = 2;
  localparam int unsigned INDEX_BITS     = 5;
  localparam int unsigned NUM_SETS       = 1 << INDEX_BITS;
  // whatever is left of the pc above index and offset is tag
  localparam int unsigned TAG_BITS       = PC_BITS - INDEX_BITS - OFFSET_BITS - INST_BYTE_BITS;
  localparam int unsigned NUM_WAYS       = 4;
  localparam int unsigned WAY_BITS       = 2;
  localparam int unsigned LINE_BITS      = INST_BITS * INSTS_IN_LINE;

  //////////////////////////////
  // typed widths
  //////////////////////////////

  typedef logic [PC_BITS-1:0]            pc_t;
  typedef logic [INST_BITS-1:0]          inst_t;
  // instruction k of a line sits at bits [k*INST_BITS +: INST_BITS]
  typedef logic [LINE_BITS-1:0]          line_t;
  typedef logic [TAG_BITS-1:0]           tag_t;
  typedef logic [INDEX_BITS-1:0]         index_t;
  typedef logic [OFFSET_BITS-1:0]        offset_t;
  typedef logic [WAY_BITS-1:0]           way_t;
  typedef logic [NUM_WAYS-1:0]           way_mask_t;
  // a line address is the tag followed by the index
  typedef logic [TAG_BITS+INDEX_BITS-1:0] block_addr_t;

  // states of the single miss status holder
  typedef enum logic [1:0] {IDLE, REQUEST, WAIT_RESP, FILL} miss_state_t;

  // block read request, valid for exactly one cycle
  typedef struct packed {
    logic        valid;
    block_addr_t addr;
  } mem_req_t;

  // block read response, it names the line it carries
  typedef struct packed {
    logic   valid;
    tag_t   tag;
    index_t index;
    line_t  data;
  } mem_resp_t;

  // line write into both stores, also steps the victim pointer
  typedef struct packed {
    logic   valid;
    way_t   way;
    index_t index;
    tag_t   tag;
    line_t  data;
  } fill_t;

endpackage

`default_nettype wire

// File: icache_properties.sv
`default_nettype none

module icache_properties (
  input logic clk,
  input logic reset,
  input logic mem_req_valid_i,
  input logic flush_i,
  input logic flush_done_i,
  input logic fill_valid_i
);

  // failed assertions, read by the testbench at the end of the run
  int assert_errors = 0;

  // high from a request until the fill or a flush closes that miss
  logic outstanding_q;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      outstanding_q <= 1'b0;
    end
    else if (fill_valid_i || flush_i)
    begin
      outstanding_q <= 1'b0;
    end
    else if (mem_req_valid_i)
    begin
      outstanding_q <= 1'b1;
    end
  end

  //////////////////////////////
  // memory handshake
  //////////////////////////////

  // the request is a single-cycle pulse
  request_one_cycle: assert property (@(posedge clk) disable iff (reset)
    mem_req_valid_i |=> !mem_req_valid_i)
  else
  begin
    $error("memory request held for more than one cycle");
    assert_errors++;
  end

  // only one miss may be in flight
  one_miss_at_a_time: assert property (@(posedge clk) disable iff (reset)
    mem_req_valid_i |-> !outstanding_q)
  else
  begin
    $error("new memory request before the previous miss ended");
    assert_errors++;
  end

  //////////////////////////////
  // flush timing
  //////////////////////////////

  flush_done_follows: assert property (@(posedge clk) disable iff (reset)
    flush_i |=> flush_done_i)
  else
  begin
    $error("flush done missing one cycle after flush");
    assert_errors++;
  end

  // done never shows up without a flush just before it
  flush_done_only_after_flush: assert property (@(posedge clk) disable iff (reset)
    !flush_i |=> !flush_done_i)
  else
  begin
    $error("flush done without a flush in the cycle before");
    assert_errors++;
  end

endmodule

`default_nettype wire

// File: icache_top.sv
`default_nettype none

module icache_top #(
  parameter int unsigned FETCH_WIDTH = 2
) (
  input  logic                   clk,
  input  logic                   reset,
  // fetch side
  input  logic                   fetch_req_i,
  input  icache_pkg::pc_t        pc_i,
  output icache_pkg::inst_t      inst_o [FETCH_WIDTH],
  output logic [FETCH_WIDTH-1:0] inst_valid_o,
  // memory side
  output icache_pkg::mem_req_t   mem_req_o,
  input  icache_pkg::mem_resp_t  mem_resp_i,
  // control
  input  logic                   flush_i,
  output logic                   flush_done_o,
  output logic                   ic_miss_o
);

  import icache_pkg::*;

  tag_t      lookup_tag;
  index_t    lookup_index;
  offset_t   lookup_offset;
  way_mask_t hit_way;
  way_t      victim_way;
  index_t    held_index;
  fill_t     fill;

  // pc layout, from the top down
  // tag, then set index, then instruction slot, then the byte bits
  assign lookup_offset = pc_i[INST_BYTE_BITS +: OFFSET_BITS];
  assign lookup_index  = pc_i[INST_BYTE_BITS+OFFSET_BITS +: INDEX_BITS];
  assign lookup_tag    = pc_i[PC_BITS-1 -: TAG_BITS];

  // a miss is reported exactly when a request goes out
  assign ic_miss_o = mem_req_o.valid;

  tag_store u_tag_store (
    .clk            (clk),
    .reset          (reset),
    .lookup_tag_i   (lookup_tag),
    .lookup_index_i (lookup_index),
    .fetch_req_i    (fetch_req_i),
    .fill_i         (fill),
    .flush_i        (flush_i),
    .hit_way_o      (hit_way),
    .flush_done_o   (flush_done_o)
  );

  data_store #(
    .FETCH_WIDTH (FETCH_WIDTH)
  ) u_data_store (
    .clk             (clk),
    .reset           (reset),
    .lookup_index_i  (lookup_index),
    .lookup_offset_i (lookup_offset),
    .hit_way_i       (hit_way),
    .fill_i          (fill),
    .inst_o          (inst_o),
    .inst_valid_o    (inst_valid_o)
  );

  miss_fsm u_miss_fsm (
    .clk            (clk),
    .reset          (reset),
    .fetch_req_i    (fetch_req_i),
    .hit_way_i      (hit_way),
    .lookup_tag_i   (lookup_tag),
    .lookup_index_i (lookup_index),
    .victim_way_i   (victim_way),
    .mem_resp_i     (mem_resp_i),
    .flush_i        (flush_i),
    .mem_req_o      (mem_req_o),
    .held_index_o   (held_index),
    .fill_o         (fill)
  );

  victim_counter u_victim_counter (
    .clk          (clk),
    .reset        (reset),
    .index_i      (held_index),
    .fill_i       (fill),
    .victim_way_o (victim_way)
  );

endmodule

`default_nettype wire

// File: miss_fsm.sv
`default_nettype none

module miss_fsm (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  fetch_req_i,
  input  icache_pkg::way_mask_t hit_way_i,
  input  icache_pkg::tag_t      lookup_tag_i,
  input  icache_pkg::index_t    lookup_index_i,
  input  icache_pkg::way_t      victim_way_i,
  input  icache_pkg::mem_resp_t mem_resp_i,
  input  logic                  flush_i,
  output icache_pkg::mem_req_t  mem_req_o,
  output icache_pkg::index_t    held_index_o,
  output icache_pkg::fill_t     fill_o
);

  import icache_pkg::*;

  miss_state_t state_q;
  miss_state_t state_d;

  // address of the miss being handled
  tag_t   held_tag_q;
  index_t held_index_q;
  // returned line and the way it will replace
  line_t  line_q;
  way_t   way_q;

  logic   miss;
  logic   resp_match;

  // a requested fetch that no way answers
  assign miss = fetch_req_i && (hit_way_i == '0);

  // only a response naming the held line is taken
  // responses for any other line are simply ignored
  assign resp_match = mem_resp_i.valid && (mem_resp_i.tag == held_tag_q) &&
                      (mem_resp_i.index == held_index_q);

  //////////////////////////////
  // state machine
  //////////////////////////////

  // misses outside IDLE are not recorded, fetch keeps replaying the pc
  // until the pending miss is done and the pc either hits or misses again
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:      if (miss) state_d = REQUEST;
      REQUEST:   state_d = WAIT_RESP;
      WAIT_RESP: if (resp_match) state_d = FILL;
      FILL:      state_d = IDLE;
      default:   state_d = IDLE;
    endcase
    // a flush abandons whatever miss is in flight
    if (flush_i)
    begin
      state_d = IDLE;
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state_q <= IDLE;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  //////////////////////////////
  // holder registers
  //////////////////////////////

  // the victim way is sampled together with the line
  // nothing else can move that set's pointer before FILL
  always_ff @(posedge clk)
  begin
    if (state_q == IDLE && miss)
    begin
      held_tag_q   <= lookup_tag_i;
      held_index_q <= lookup_index_i;
    end
    if (state_q == WAIT_RESP && resp_match)
    begin
      line_q <= mem_resp_i.data;
      way_q  <= victim_way_i;
    end
  end

  //////////////////////////////
  // outputs
  //////////////////////////////

  // REQUEST lasts one cycle, which gives the one-cycle request pulse
  always_comb
  begin
    mem_req_o.valid = (state_q == REQUEST);
    mem_req_o.addr  = {held_tag_q, held_index_q};
  end

  // fill is presented for the single FILL cycle
  always_comb
  begin
    fill_o.valid = (state_q == FILL) && !flush_i;
    fill_o.way   = way_q;
    fill_o.index = held_index_q;
    fill_o.tag   = held_tag_q;
    fill_o.data  = line_q;
  end

  assign held_index_o = held_index_q;

endmodule

`default_nettype wire

// File: src.f
icache_pkg.sv
tag_store.sv
data_store.sv
miss_fsm.sv
victim_counter.sv
icache_top.sv
icache_properties.sv
icache_checker.sv
tb_icache.sv

// File: tag_store.sv
`default_nettype none

module tag_store (
  input  logic                  clk,
  input  logic                  reset,
  input  icache_pkg::tag_t      lookup_tag_i,
  input  icache_pkg::index_t    lookup_index_i,
  input  logic                  fetch_req_i,
  input  icache_pkg::fill_t     fill_i,
  input  logic                  flush_i,
  output icache_pkg::way_mask_t hit_way_o,
  output logic                  flush_done_o
);

  import icache_pkg::*;

  // one tag and one valid bit per way and set
  tag_t      tag_q   [NUM_SETS][NUM_WAYS];
  way_mask_t valid_q [NUM_SETS];

  //////////////////////////////
  // lookup
  //////////////////////////////

  // all ways are compared in parallel in the fetch cycle
  // a way only hits while fetch is actually asking, so an idle fetch
  // stage never looks like a hit or a miss to the miss handler
  always_comb
  begin
    for (int w = 0; w < NUM_WAYS; w++)
    begin
      hit_way_o[w] = fetch_req_i && valid_q[lookup_index_i][w] &&
                     (tag_q[lookup_index_i][w] == lookup_tag_i);
    end
  end

  //////////////////////////////
  // update
  //////////////////////////////

  // the tag is written on every fill of its way
  // a stale tag is harmless since the valid bit guards the compare
  always_ff @(posedge clk)
  begin
    if (fill_i.valid)
    begin
      tag_q[fill_i.index][fill_i.way] <= fill_i.tag;
    end
  end

  // flush has priority over a fill in the same cycle
  // the miss handler also drops its fill on a flush, so both agree
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      valid_q <= '{default: '0};
    end
    else if (flush_i)
    begin
      valid_q <= '{default: '0};
    end
    else if (fill_i.valid)
    begin
      valid_q[fill_i.index][fill_i.way] <= 1'b1;
    end
  end

  // flush takes one edge, so done follows one cycle later
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      flush_done_o <= 1'b0;
    end
    else
    begin
      flush_done_o <= flush_i;
    end
  end

endmodule

`default_nettype wire

// File: tb_icache.sv
`default_nettype none

module tb_icache;

  import icache_pkg::*;

  localparam int unsigned FETCH_WIDTH   = 2;
  localparam int          HALF_PERIOD   = 20;
  localparam int          STIM_DELAY    = 2;
  localparam int          REPLAY_LIMIT  = 64;
  localparam int          RANDOM_ROUNDS = 48;
  localparam logic [31:0] LFSR_SEED     = 32'd88923;
  localparam tag_t        POOL_TAG      = 23'h2a5c0;
  localparam tag_t        RR_TAG        = 23'h13370;
  localparam index_t      RR_SET        = 5'd9;

  logic                   clk;
  logic                   reset;
  logic                   fetch_req;
  pc_t                    pc;
  inst_t                  inst [FETCH_WIDTH];
  logic [FETCH_WIDTH-1:0] inst_valid;
  mem_req_t               mem_req;
  mem_resp_t              mem_resp;
  logic                   flush;
  logic                   flush_done;
  logic                   ic_miss;
  int                     error_count;

  // separate generators for fetch stimulus and for the memory model
  logic [31:0]            stim_lfsr;
  logic [31:0]            mem_lfsr;
  // line addresses requested and not yet answered
  block_addr_t            req_queue [$];

  icache_top #(
    .FETCH_WIDTH (FETCH_WIDTH)
  ) DUT (
    .clk          (clk),
    .reset        (reset),
    .fetch_req_i  (fetch_req),
    .pc_i         (pc),
    .inst_o       (inst),
    .inst_valid_o (inst_valid),
    .mem_req_o    (mem_req),
    .mem_resp_i   (mem_resp),
    .flush_i      (flush),
    .flush_done_o (flush_done),
    .ic_miss_o    (ic_miss)
  );

  icache_checker #(
    .FETCH_WIDTH (FETCH_WIDTH)
  ) u_checker (
    .clk           (clk),
    .reset         (reset),
    .fetch_req_i   (fetch_req),
    .pc_i          (pc),
    .inst_i        (inst),
    .inst_valid_i  (inst_valid),
    .mem_req_i     (mem_req),
    .mem_resp_i    (mem_resp),
    .flush_i       (flush),
    .flush_done_i  (flush_done),
    .ic_miss_i     (ic_miss),
    .error_count_o (error_count)
  );

  bind icache_top icache_properties u_properties (
    .clk             (clk),
    .reset           (reset),
    .mem_req_valid_i (mem_req_o.valid),
    .flush_i         (flush_i),
    .flush_done_i    (flush_done_o),
    .fill_valid_i    (fill.valid)
  );

  always #HALF_PERIOD clk = ~clk;

  //////////////////////////////
  // helpers
  //////////////////////////////

  // 32-bit Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  task automatic take_bits(inout logic [31:0] state, input int count,
                           output logic [31:0] value);
    value = '0;
    for (int b = 0; b < count; b++)
    begin
      state = lfsr_next(state);
      value = {value[30:0], state[0]};
    end
  endtask

  function automatic pc_t make_pc(input tag_t tag, input index_t index, input offset_t offset);
    return {tag, index, offset, 2'b00};
  endfunction

  // eight tags over four sets, so sets are revisited and ways get evicted
  function automatic pc_t pool_pc(input logic [6:0] r);
    return make_pc(tag_t'(POOL_TAG + r[2:0]), index_t'(r[4:3]), offset_t'(r[6:5]));
  endfunction

  function automatic line_t block_line(input tag_t tag, input index_t index);
    line_t line;
    for (int k = 0; k < INSTS_IN_LINE; k++)
    begin
      line[k*INST_BITS +: INST_BITS] = {tag, index, 4'(k)};
    end
    return line;
  endfunction

  task automatic fetch_once(input pc_t fetch_pc);
    fetch_req = 1'b1;
    pc        = fetch_pc;
    @(posedge clk);
    #STIM_DELAY;
  endtask

  // replays the pc until slot 0 comes back valid
  task automatic fetch_until_hit(input pc_t fetch_pc);
    int   cycles;
    logic hit;
    cycles = 0;
    hit    = 1'b0;
    while (!hit && cycles < REPLAY_LIMIT)
    begin
      fetch_req = 1'b1;
      pc        = fetch_pc;
      @(negedge clk);
      hit = inst_valid[0];
      @(posedge clk);
      #STIM_DELAY;
      cycles++;
    end
    if (!hit)
    begin
      $display("timeout: pc %h did not hit within %0d cycles", fetch_pc, REPLAY_LIMIT);
      $display("*** FAILED ***");
      $finish;
    end
  endtask

  task automatic do_flush();
    fetch_req = 1'b0;
    flush     = 1'b1;
    @(posedge clk);
    #STIM_DELAY;
    flush = 1'b0;
  endtask

  task automatic idle_cycles(input int count);
    fetch_req = 1'b0;
    repeat (count)
    begin
      @(posedge clk);
      #STIM_DELAY;
    end
  endtask

  task automatic send_response(input tag_t tag, input index_t index);
    mem_resp.valid = 1'b1;
    mem_resp.tag   = tag;
    mem_resp.index = index;
    mem_resp.data  = block_line(tag, index);
    @(posedge clk);
    #STIM_DELAY;
    mem_resp = '0;
  endtask

  //////////////////////////////
  // memory model
  //////////////////////////////

  always @(negedge clk)
  begin
    if (!reset && mem_req.valid)
    begin
      req_queue.push_back(mem_req.addr);
    end
  end

  // answers each request one to eight cycles later
  // about half of the answers are led by a response for the wrong tag
  always
  begin : responder
    block_addr_t addr;
    logic [31:0] r;

    @(posedge clk);
    #STIM_DELAY;
    if (!reset && req_queue.size() != 0)
    begin
      addr = req_queue.pop_front();
      take_bits(mem_lfsr, 4, r);
      repeat (r[2:0])
      begin
        @(posedge clk);
        #STIM_DELAY;
      end
      if (r[3])
      begin
        send_response(addr[INDEX_BITS +: TAG_BITS] ^ tag_t'(1), addr[INDEX_BITS-1:0]);
      end
      send_response(addr[INDEX_BITS +: TAG_BITS], addr[INDEX_BITS-1:0]);
    end
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial
  begin : stimulus
    logic [31:0] r;
    pc_t         pc_a;
    pc_t         pc_b;
    pc_t         first_pc;
    pc_t         flush_pc;

    clk       = 1'b0;
    reset     = 1'b1;
    fetch_req = 1'b0;
    pc        = '0;
    flush     = 1'b0;
    mem_resp  = '0;
    stim_lfsr = LFSR_SEED;
    mem_lfsr  = LFSR_SEED;
    repeat (2) @(posedge clk);
    #STIM_DELAY;
    reset = 1'b0;

    // random fetches from the pool, with back-pressure misses and flushes
    for (int n = 0; n < RANDOM_ROUNDS; n++)
    begin
      take_bits(stim_lfsr, 7, r);
      pc_a = pool_pc(r[6:0]);
      take_bits(stim_lfsr, 4, r);
      if (r[3:0] == 4'd0)
      begin
        do_flush();
      end
      else if (r[3:0] < 4'd6)
      begin
        // a second pc right behind the first one usually misses while busy
        fetch_once(pc_a);
        take_bits(stim_lfsr, 7, r);
        pc_b = pool_pc(r[6:0]);
        fetch_once(pc_b);
      end
      fetch_until_hit(pc_a);
    end

    // five tags into one set, the fifth replaces the first
    for (int k = 0; k <= NUM_WAYS; k++)
    begin
      fetch_until_hit(make_pc(tag_t'(RR_TAG + k), RR_SET, offset_t'(k)));
    end
    first_pc = make_pc(RR_TAG, RR_SET, 2'd0);
    fetch_once(first_pc);
    fetch_until_hit(first_pc);

    // a flush empties a resident line, then one lands on a fresh request
    flush_pc = make_pc(tag_t'(RR_TAG + NUM_WAYS), RR_SET, 2'd3);
    fetch_until_hit(flush_pc);
    do_flush();
    fetch_once(flush_pc);
    do_flush();
    fetch_until_hit(flush_pc);
    idle_cycles(4);

    u_checker.print_counts(DUT.u_properties.assert_errors);
    if (error_count == 0 && DUT.u_properties.assert_errors == 0)
    begin
      $display("*** PASSED ***");
    end
    else
    begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: victim_counter.sv
`default_nettype none

module victim_counter (
  input  logic               clk,
  input  logic               reset,
  input  icache_pkg::index_t index_i,
  input  icache_pkg::fill_t  fill_i,
  output icache_pkg::way_t   victim_way_o
);

  import icache_pkg::*;

  // next way to replace in each set
  way_t ptr_q [NUM_SETS];

  // victim for the set the miss handler is working on
  assign victim_way_o = ptr_q[index_i];

  // every fill moves its set's pointer on by one way, wrapping at NUM_WAYS
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      ptr_q <= '{default: '0};
    end
    else if (fill_i.valid)
    begin
      if (ptr_q[fill_i.index] == way_t'(NUM_WAYS - 1))
      begin
        ptr_q[fill_i.index] <= '0;
      end
      else
      begin
        ptr_q[fill_i.index] <= ptr_q[fill_i.index] + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire
